/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = tb_core
FILELIST  = vlog.f
PASS_MSG  = Simulation finished: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir

/* core.sv */
`timescale 1ns/1ps
`include "core_defs.svh"

module core import core_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [`CORE_XLEN-1:0] instr,
    input  logic                  instruction_grant,
    output logic [`CORE_XLEN-1:0] pc,
    output dmem_req_t             dmem_req,
    input  logic [`CORE_XLEN-1:0] dmem_rdata
);

    localparam if_id_t IF_ID_BUBBLE = '{pc: '0, instr: `CORE_NOP};

    if_id_t    if_id_d, if_id_q;
    id_ex_t    id_ex_d, id_ex_q;
    ex_mem_t   ex_mem_d, ex_mem_q;
    mem_wb_t   mem_wb_d, mem_wb_q;
    redirect_t redirect;
    fwd_sel_e  fwd_a, fwd_b;

    logic [`CORE_REG_ADDR_W-1:0] dec_rs1, dec_rs2;
    logic [`CORE_XLEN-1:0]       rs1_data, rs2_data;
    logic [`CORE_XLEN-1:0]       wb_data;
    logic                        stall_global;
    logic                        stall_load_use;
    logic                        flush_front;   // Redirect taken this cycle

    // ==================================================================
    // Stall and flush control
    // ==================================================================

    assign stall_global = !instruction_grant;  // Fetch not ready, freeze all
    assign flush_front  = redirect.valid && instruction_grant;

    // ==================================================================
    // Fetch
    // ==================================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= `CORE_RESET_PC;
        end else if (instruction_grant) begin
            if (redirect.valid) begin
                pc <= redirect.target;
            end else if (!stall_load_use) begin
                pc <= pc + 4;
            end
        end
    end

    assign if_id_d = '{pc: pc, instr: instr};

    pipe_reg #(.payload_t(if_id_t), .BUBBLE(IF_ID_BUBBLE)) i_if_id (
        .clk   (clk),
        .rst_n (rst_n),
        .stall (stall_global || stall_load_use),
        .flush (flush_front),
        .d     (if_id_d),
        .q     (if_id_q)
    );

    // ==================================================================
    // Decode
    // ==================================================================

    regfile i_regfile (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1      (dec_rs1),
        .rs2      (dec_rs2),
        .rd       (mem_wb_q.rd),
        .we       (mem_wb_q.reg_write),
        .wdata    (wb_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    decode_stage i_decode (
        .if_id    (if_id_q),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .rs1      (dec_rs1),
        .rs2      (dec_rs2),
        .id_ex    (id_ex_d)
    );

    hazard_unit i_hazard (
        .rs1              (dec_rs1),
        .rs2              (dec_rs2),
        .id_ex            (id_ex_q),
        .ex_mem_rd        (ex_mem_q.rd),
        .ex_mem_reg_write (ex_mem_q.reg_write),
        .mem_wb_rd        (mem_wb_q.rd),
        .mem_wb_reg_write (mem_wb_q.reg_write),
        .stall_load_use   (stall_load_use),
        .fwd_a            (fwd_a),
        .fwd_b            (fwd_b)
    );

    // Load-use inserts the bubble here
    pipe_reg #(.payload_t(id_ex_t)) i_id_ex (
        .clk   (clk),
        .rst_n (rst_n),
        .stall (stall_global),
        .flush (flush_front || (stall_load_use && instruction_grant)),
        .d     (id_ex_d),
        .q     (id_ex_q)
    );

    // ==================================================================
    // Execute, memory and writeback
    // ==================================================================

    execute_stage i_execute (
        .id_ex      (id_ex_q),
        .fwd_a      (fwd_a),
        .fwd_b      (fwd_b),
        .mem_result (ex_mem_q.result),
        .wb_result  (wb_data),
        .ex_mem     (ex_mem_d),
        .redirect   (redirect)
    );

    pipe_reg #(.payload_t(ex_mem_t)) i_ex_mem (
        .clk   (clk),
        .rst_n (rst_n),
        .stall (stall_global),
        .flush (1'b0),
        .d     (ex_mem_d),
        .q     (ex_mem_q)
    );

    // Strobes only in cycles where the stage advances
    assign dmem_req.read  = ex_mem_q.mem_read && instruction_grant;
    assign dmem_req.write = ex_mem_q.mem_write && instruction_grant;
    assign dmem_req.addr  = ex_mem_q.result;
    assign dmem_req.wdata = ex_mem_q.store_data;

    assign mem_wb_d = '{
        reg_write: ex_mem_q.reg_write,
        mem_read:  ex_mem_q.mem_read,
        result:    ex_mem_q.result,
        load_data: dmem_rdata,
        rd:        ex_mem_q.rd
    };

    pipe_reg #(.payload_t(mem_wb_t)) i_mem_wb (
        .clk   (clk),
        .rst_n (rst_n),
        .stall (stall_global),
        .flush (1'b0),
        .d     (mem_wb_d),
        .q     (mem_wb_q)
    );

    assign wb_data = mem_wb_q.mem_read ? mem_wb_q.load_data : mem_wb_q.result;

endmodule

/* core_asserts.sv */
`timescale 1ns/1ps
`include "core_defs.svh"

module core_asserts import core_pkg::*; (
    input logic                  clk,
    input logic                  rst_n,
    input logic                  instruction_grant,
    input logic [`CORE_XLEN-1:0] pc,
    input dmem_req_t             dmem_req
);

    logic [1:0] since_reset;  // Saturates at 3
    int         fail_count = 0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            since_reset <= '0;
        end else if (since_reset < 2'd3) begin
            since_reset <= since_reset + 2'd1;
        end
    end

    // A store held by a stall strobes once, not again after the stall
    assert property (@(posedge clk) disable iff (!rst_n)
        dmem_req.write |=> !(dmem_req.write && $stable(dmem_req.addr) &&
                             $stable(dmem_req.wdata)))
        else begin
            fail_count++;
            $error("store strobe repeated for one store");
        end

    assert property (@(posedge clk) disable iff (!rst_n)
        !instruction_grant |=> pc == $past(pc))
        else begin
            fail_count++;
            $error("pc moved during a stalled cycle");
        end

    // Pipeline holds only bubbles until the first fetch reaches memory
    assert property (@(posedge clk) disable iff (!rst_n)
        since_reset < 2'd3 |-> !(dmem_req.read || dmem_req.write))
        else begin
            fail_count++;
            $error("memory strobe before the first fetch could reach memory");
        end

endmodule

bind core core_asserts i_asserts (.*);

/* core_defs.svh */
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// ======================================================================
// Core-wide sizes and constants
// ======================================================================

// Datapath and address width
`define CORE_XLEN        32

// Architectural register file
`define CORE_REG_COUNT   32
`define CORE_REG_ADDR_W  5

// First fetch address out of reset
`define CORE_RESET_PC    32'h0000_0000

// ADDI x0,x0,0
`define CORE_NOP         32'h0000_0013

`endif

/* core_pkg.sv */
`include "core_defs.svh"

package core_pkg;

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B  // LUI
    } alu_op_e;

    typedef struct packed {
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    branch;
        logic    jump;
        logic    is_jalr;
        logic    alu_src_imm;
        alu_op_e alu_op;
    } ctrl_t;

    // ==================================================================
    // Stage boundary payloads
    // ==================================================================

    typedef struct packed {
        logic [`CORE_XLEN-1:0] pc;
        logic [`CORE_XLEN-1:0] instr;
    } if_id_t;

    typedef struct packed {
        ctrl_t                       ctrl;
        logic [`CORE_XLEN-1:0]       pc;
        logic [`CORE_XLEN-1:0]       rs1_data;
        logic [`CORE_XLEN-1:0]       rs2_data;
        logic [`CORE_XLEN-1:0]       imm;
        logic [`CORE_REG_ADDR_W-1:0] rs1;
        logic [`CORE_REG_ADDR_W-1:0] rs2;
        logic [`CORE_REG_ADDR_W-1:0] rd;
        logic [2:0]                  funct3;
    } id_ex_t;

    typedef struct packed {
        logic                        reg_write;
        logic                        mem_read;
        logic                        mem_write;
        logic [`CORE_XLEN-1:0]       result;      // ALU result or link address
        logic [`CORE_XLEN-1:0]       store_data;
        logic [`CORE_REG_ADDR_W-1:0] rd;
    } ex_mem_t;

    typedef struct packed {
        logic                        reg_write;
        logic                        mem_read;
        logic [`CORE_XLEN-1:0]       result;
        logic [`CORE_XLEN-1:0]       load_data;
        logic [`CORE_REG_ADDR_W-1:0] rd;
    } mem_wb_t;

    typedef enum logic [1:0] {
        FWD_NONE,
        FWD_MEM,
        FWD_WB
    } fwd_sel_e;

    typedef struct packed {
        logic                  read;
        logic                  write;
        logic [`CORE_XLEN-1:0] addr;
        logic [`CORE_XLEN-1:0] wdata;
    } dmem_req_t;

    typedef struct packed {
        logic                  valid;
        logic [`CORE_XLEN-1:0] target;
    } redirect_t;

endpackage

/* decode_stage.sv */
`timescale 1ns/1ps
`include "core_defs.svh"

module decode_stage import core_pkg::*; (
    input  if_id_t                      if_id,
    input  logic [`CORE_XLEN-1:0]       rs1_data,
    input  logic [`CORE_XLEN-1:0]       rs2_data,
    output logic [`CORE_REG_ADDR_W-1:0] rs1,
    output logic [`CORE_REG_ADDR_W-1:0] rs2,
    output id_ex_t                      id_ex
);

    logic [`CORE_XLEN-1:0] instr;
    logic [6:0]            opcode;
    logic [2:0]            funct3;
    logic [`CORE_XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;
    logic [`CORE_XLEN-1:0] imm;
    ctrl_t                 ctrl;

    // ==================================================================
    // Field extraction
    // ==================================================================

    assign instr  = if_id.instr;
    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    // ==================================================================
    // Control generation
    // ==================================================================

    always_comb begin
        ctrl = '0;  // Bubble unless recognised
        imm  = '0;
        case (opcode)
            OPC_OP: begin
                ctrl.reg_write = 1'b1;
                case (funct3)
                    3'b000:  ctrl.alu_op = instr[30] ? ALU_SUB : ALU_ADD;
                    3'b010:  ctrl.alu_op = ALU_SLT;
                    3'b100:  ctrl.alu_op = ALU_XOR;
                    3'b110:  ctrl.alu_op = ALU_OR;
                    3'b111:  ctrl.alu_op = ALU_AND;
                    default: ctrl = '0;  // Shifts, SLTU
                endcase
            end
            OPC_OP_IMM: begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                imm              = imm_i;
                case (funct3)
                    3'b000:  ctrl.alu_op = ALU_ADD;
                    3'b100:  ctrl.alu_op = ALU_XOR;
                    3'b110:  ctrl.alu_op = ALU_OR;
                    3'b111:  ctrl.alu_op = ALU_AND;
                    default: ctrl = '0;
                endcase
            end
            OPC_LUI: begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.alu_op      = ALU_PASS_B;
                imm              = imm_u;
            end
            OPC_LOAD: begin
                if (funct3 == 3'b010) begin  // LW only
                    ctrl.reg_write   = 1'b1;
                    ctrl.mem_read    = 1'b1;
                    ctrl.alu_src_imm = 1'b1;
                end
                imm = imm_i;
            end
            OPC_STORE: begin
                if (funct3 == 3'b010) begin  // SW only
                    ctrl.mem_write   = 1'b1;
                    ctrl.alu_src_imm = 1'b1;
                end
                imm = imm_s;
            end
            OPC_BRANCH: begin
                ctrl.branch = (funct3 == 3'b000) || (funct3 == 3'b001) || (funct3 == 3'b100);
                imm         = imm_b;
            end
            OPC_JAL: begin
                ctrl.reg_write = 1'b1;
                ctrl.jump      = 1'b1;
                imm            = imm_j;
            end
            OPC_JALR: begin
                ctrl.reg_write   = 1'b1;
                ctrl.jump        = 1'b1;
                ctrl.is_jalr     = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                imm              = imm_i;
            end
            default: ctrl = '0;
        endcase
    end

    assign id_ex = '{
        ctrl:     ctrl,
        pc:       if_id.pc,
        rs1_data: rs1_data,
        rs2_data: rs2_data,
        imm:      imm,
        rs1:      rs1,
        rs2:      rs2,
        rd:       instr[11:7],
        funct3:   funct3
    };

endmodule

/* execute_stage.sv */
`timescale 1ns/1ps
`include "core_defs.svh"

module execute_stage import core_pkg::*; (
    input  id_ex_t                id_ex,
    input  fwd_sel_e              fwd_a,
    input  fwd_sel_e              fwd_b,
    input  logic [`CORE_XLEN-1:0] mem_result,
    input  logic [`CORE_XLEN-1:0] wb_result,
    output ex_mem_t               ex_mem,
    output redirect_t             redirect
);

    logic [`CORE_XLEN-1:0] op_a;
    logic [`CORE_XLEN-1:0] op_b;     // rs2 after forwarding, also store data
    logic [`CORE_XLEN-1:0] alu_b;
    logic [`CORE_XLEN-1:0] alu_out;
    logic [`CORE_XLEN-1:0] jalr_sum;
    logic                  cond_met;

    function automatic logic [`CORE_XLEN-1:0] fwd_mux(
        input fwd_sel_e              sel,
        input logic [`CORE_XLEN-1:0] reg_val
    );
        logic [`CORE_XLEN-1:0] val;
        case (sel)
            FWD_MEM: val = mem_result;
            FWD_WB:  val = wb_result;
            default: val = reg_val;
        endcase
        return val;
    endfunction

    // ==================================================================
    // Operands and ALU
    // ==================================================================

    assign op_a  = fwd_mux(fwd_a, id_ex.rs1_data);
    assign op_b  = fwd_mux(fwd_b, id_ex.rs2_data);
    assign alu_b = id_ex.ctrl.alu_src_imm ? id_ex.imm : op_b;

    always_comb begin
        case (id_ex.ctrl.alu_op)
            ALU_ADD:    alu_out = op_a + alu_b;
            ALU_SUB:    alu_out = op_a - alu_b;
            ALU_AND:    alu_out = op_a & alu_b;
            ALU_OR:     alu_out = op_a | alu_b;
            ALU_XOR:    alu_out = op_a ^ alu_b;
            ALU_SLT:    alu_out = {31'b0, $signed(op_a) < $signed(alu_b)};
            ALU_PASS_B: alu_out = alu_b;
            default:    alu_out = '0;
        endcase
    end

    // ==================================================================
    // Branch compare and redirect
    // ==================================================================

    always_comb begin
        case (id_ex.funct3)
            3'b000:  cond_met = (op_a == op_b);                    // BEQ
            3'b001:  cond_met = (op_a != op_b);                    // BNE
            3'b100:  cond_met = ($signed(op_a) < $signed(op_b));   // BLT
            default: cond_met = 1'b0;
        endcase
    end

    assign jalr_sum = op_a + id_ex.imm;

    // Not-taken is the only prediction, so any taken transfer redirects
    assign redirect.valid  = id_ex.ctrl.jump || (id_ex.ctrl.branch && cond_met);
    assign redirect.target = id_ex.ctrl.is_jalr ? {jalr_sum[`CORE_XLEN-1:1], 1'b0}
                                                : id_ex.pc + id_ex.imm;

    assign ex_mem = '{
        reg_write:  id_ex.ctrl.reg_write,
        mem_read:   id_ex.ctrl.mem_read,
        mem_write:  id_ex.ctrl.mem_write,
        result:     id_ex.ctrl.jump ? id_ex.pc + 4 : alu_out,  // Link address
        store_data: op_b,
        rd:         id_ex.rd
    };

endmodule

/* hazard_unit.sv */
`timescale 1ns/1ps
`include "core_defs.svh"

module hazard_unit import core_pkg::*; (
    input  logic [`CORE_REG_ADDR_W-1:0] rs1,
    input  logic [`CORE_REG_ADDR_W-1:0] rs2,
    input  id_ex_t                      id_ex,
    input  logic [`CORE_REG_ADDR_W-1:0] ex_mem_rd,
    input  logic                        ex_mem_reg_write,
    input  logic [`CORE_REG_ADDR_W-1:0] mem_wb_rd,
    input  logic                        mem_wb_reg_write,
    output logic                        stall_load_use,
    output fwd_sel_e                    fwd_a,
    output fwd_sel_e                    fwd_b
);

    // Younger writer in EX/MEM wins over MEM/WB
    function automatic fwd_sel_e pick(input logic [`CORE_REG_ADDR_W-1:0] src);
        fwd_sel_e sel;
        if (src == '0) begin
            sel = FWD_NONE;  // x0 always reads zero
        end else if (ex_mem_reg_write && ex_mem_rd == src) begin
            sel = FWD_MEM;
        end else if (mem_wb_reg_write && mem_wb_rd == src) begin
            sel = FWD_WB;
        end else begin
            sel = FWD_NONE;
        end
        return sel;
    endfunction

    assign fwd_a = pick(id_ex.rs1);
    assign fwd_b = pick(id_ex.rs2);

    // ==================================================================
    // Load-use detection
    // ==================================================================

    // Load data only exists after MEM, so decode waits one cycle
    assign stall_load_use = id_ex.ctrl.mem_read && (id_ex.rd != '0) &&
                            ((id_ex.rd == rs1) || (id_ex.rd == rs2));

endmodule

/* pipe_reg.sv */
`timescale 1ns/1ps

// One stage boundary of the pipeline, shared by all four boundaries
module pipe_reg #(
    parameter type      payload_t = logic,
    parameter payload_t BUBBLE    = '0
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     stall,
    input  logic     flush,
    input  payload_t d,
    output payload_t q
);

    // Flush has priority over stall
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q <= BUBBLE;
        end else if (flush) begin
            q <= BUBBLE;
        end else if (!stall) begin
            q <= d;
        end
        // Otherwise hold
    end

endmodule

/* regfile.sv */
`timescale 1ns/1ps
`include "core_defs.svh"

module regfile (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [`CORE_REG_ADDR_W-1:0] rs1,
    input  logic [`CORE_REG_ADDR_W-1:0] rs2,
    input  logic [`CORE_REG_ADDR_W-1:0] rd,
    input  logic                        we,
    input  logic [`CORE_XLEN-1:0]       wdata,
    output logic [`CORE_XLEN-1:0]       rs1_data,
    output logic [`CORE_XLEN-1:0]       rs2_data
);

    // x0 has no storage
    logic [`CORE_XLEN-1:0] regs [1:`CORE_REG_COUNT-1];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < `CORE_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin
            regs[rd] <= wdata;
        end
    end

    // Same-cycle write is visible to decode
    assign rs1_data = (rs1 == '0)              ? '0    :
                      (we && rd == rs1)        ? wdata : regs[rs1];
    assign rs2_data = (rs2 == '0)              ? '0    :
                      (we && rd == rs2)        ? wdata : regs[rs2];

endmodule

/* tb_core.sv */
`timescale 1ns/1ps
`include "core_defs.svh"

module tb_core import core_pkg::*; ();

    localparam int NUM_ROWS    = 4;
    localparam int PROG_WORDS  = 32;
    localparam int MAX_STORES  = 16;
    localparam int ROW_CYCLES  = 400;
    localparam logic [31:0] MARKER_ADDR = 32'h0000_0100;

    logic                  clk;
    logic                  rst_n;
    logic [`CORE_XLEN-1:0] instr;
    logic                  instruction_grant;
    logic [`CORE_XLEN-1:0] pc;
    dmem_req_t             dmem_req;
    logic [`CORE_XLEN-1:0] dmem_rdata;

    logic [31:0] imem [0:PROG_WORDS-1];
    logic [31:0] dmem [0:255];
    logic [31:0] st_addr [$];
    logic [31:0] st_data [$];
    int          loads;

    // Program and expected store table
    string       row_name  [NUM_ROWS];
    logic [31:0] prog      [NUM_ROWS][PROG_WORDS];
    int          prog_len  [NUM_ROWS];
    logic [31:0] exp_addr  [NUM_ROWS][MAX_STORES];
    logic [31:0] exp_data  [NUM_ROWS][MAX_STORES];
    int          exp_count [NUM_ROWS];
    int          exp_loads [NUM_ROWS];

    int     seed;
    int     errors;
    bit     timed_out;

    core i_dut (
        .clk               (clk),
        .rst_n             (rst_n),
        .instr             (instr),
        .instruction_grant (instruction_grant),
        .pc                (pc),
        .dmem_req          (dmem_req),
        .dmem_rdata        (dmem_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ==================================================================
    // Memory models
    // ==================================================================

    assign instr      = imem[pc[6:2]];
    assign dmem_rdata = dmem[dmem_req.addr[9:2]];

    // Reset value of each data word, spread over the whole address
    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return (addr * 32'h9E37_79B1) ^ 32'h5A5A_5A5A;
    endfunction

    always @(posedge clk) begin
        if (!rst_n) begin
            for (int k = 0; k < 256; k++) begin
                dmem[k] <= fill_word(k * 4);
            end
            st_addr.delete();
            st_data.delete();
            loads = 0;
        end else begin
            if (dmem_req.write) begin
                dmem[dmem_req.addr[9:2]] <= dmem_req.wdata;
                st_addr.push_back(dmem_req.addr);
                st_data.push_back(dmem_req.wdata);
            end
            if (dmem_req.read) begin
                loads++;  // One strobe per load
            end
        end
    end

    // Fetch ready on roughly three cycles in four
    always @(posedge clk) begin
        instruction_grant <= (($random(seed) & 3) != 0);
    end

    // ==================================================================
    // Instruction encoders
    // ==================================================================

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input int rs2, input int rs1,
                                          input logic [2:0] f3, input int rd);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], 7'h33};
    endfunction

    function automatic logic [31:0] enc_i(input int imm, input int rs1, input logic [2:0] f3,
                                          input int rd, input logic [6:0] op);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], op};
    endfunction

    function automatic logic [31:0] enc_sw(input int imm, input int rs2, input int rs1);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] enc_b(input int imm, input int rs2, input int rs1,
                                          input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic logic [31:0] enc_lui(input logic [19:0] imm, input int rd);
        return {imm, rd[4:0], 7'h37};
    endfunction

    function automatic logic [31:0] enc_jal(input int imm, input int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'h6f};
    endfunction

    task automatic put(input int row, input logic [31:0] word);
        prog[row][prog_len[row]] = word;
        prog_len[row]++;
    endtask

    task automatic expect_store(input int row, input logic [31:0] addr, input logic [31:0] data);
        exp_addr[row][exp_count[row]] = addr;
        exp_data[row][exp_count[row]] = data;
        exp_count[row]++;
    endtask

    // ==================================================================
    // Table contents
    // ==================================================================

    task automatic build_table();
        logic [31:0] p40;
        for (int r = 0; r < NUM_ROWS; r++) begin
            prog_len[r]  = 0;
            exp_count[r] = 0;
            exp_loads[r] = 0;
        end
        // Dependent ALU chain, every result forwarded
        row_name[0] = "alu_forwarding";
        put(0, enc_lui(20'h12345, 1));
        put(0, enc_i(12'h678, 1, 3'b000, 2, 7'h13));
        put(0, enc_r(7'h20, 1, 2, 3'b000, 3));          // sub x3,x2,x1
        put(0, enc_i(-5, 0, 3'b000, 4, 7'h13));
        put(0, enc_r(7'h00, 3, 4, 3'b010, 5));          // slt x5,x4,x3
        put(0, enc_r(7'h00, 4, 2, 3'b100, 6));          // xor
        put(0, enc_r(7'h00, 5, 3, 3'b110, 7));          // or
        put(0, enc_i(12'h0f0, 2, 3'b111, 8, 7'h13));    // andi
        put(0, enc_r(7'h00, 3, 2, 3'b000, 9));          // add
        put(0, enc_sw(28, 9, 0));
        put(0, enc_sw(0, 1, 0));
        put(0, enc_sw(4, 2, 0));
        put(0, enc_sw(8, 3, 0));
        put(0, enc_sw(12, 5, 0));
        put(0, enc_sw(16, 6, 0));
        put(0, enc_sw(20, 7, 0));
        put(0, enc_sw(24, 8, 0));
        put(0, enc_sw(MARKER_ADDR, 0, 0));
        expect_store(0, 28, 32'h1234_5CF0);
        expect_store(0, 0,  32'h1234_5000);
        expect_store(0, 4,  32'h1234_5678);
        expect_store(0, 8,  32'h0000_0678);
        expect_store(0, 12, 32'h0000_0001);
        expect_store(0, 16, 32'hEDCB_A983);
        expect_store(0, 20, 32'h0000_0679);
        expect_store(0, 24, 32'h0000_0070);
        expect_store(0, MARKER_ADDR, 32'h0);
        // Loads consumed by the very next instruction
        row_name[1] = "load_use";
        p40 = fill_word(32'h40);
        put(1, enc_i(12'h040, 0, 3'b010, 1, 7'h03));
        put(1, enc_i(1, 1, 3'b000, 2, 7'h13));
        put(1, enc_sw(0, 2, 0));
        put(1, enc_i(0, 0, 3'b010, 3, 7'h03));
        put(1, enc_r(7'h00, 3, 3, 3'b000, 4));
        put(1, enc_sw(4, 4, 0));
        put(1, enc_i(12'h044, 0, 3'b010, 5, 7'h03));
        put(1, enc_sw(8, 5, 0));                        // Loaded value as store data
        put(1, enc_sw(MARKER_ADDR, 0, 0));
        expect_store(1, 0, p40 + 1);
        expect_store(1, 4, (p40 + 1) * 2);
        expect_store(1, 8, fill_word(32'h44));
        expect_store(1, MARKER_ADDR, 32'h0);
        exp_loads[1] = 3;
        // Branches and jumps; stores to 0x80 and up are off the path
        row_name[2] = "control_flow";
        put(2, enc_i(5, 0, 3'b000, 1, 7'h13));
        put(2, enc_i(5, 0, 3'b000, 2, 7'h13));
        put(2, enc_b(8, 2, 1, 3'b000));                 // beq taken
        put(2, enc_sw(12'h080, 1, 0));
        put(2, enc_b(8, 2, 1, 3'b001));                 // bne not taken
        put(2, enc_sw(0, 1, 0));
        put(2, enc_i(-1, 0, 3'b000, 3, 7'h13));
        put(2, enc_b(8, 1, 3, 3'b100));                 // blt taken
        put(2, enc_sw(12'h084, 1, 0));
        put(2, enc_b(8, 3, 1, 3'b100));                 // blt not taken
        put(2, enc_b(8, 3, 1, 3'b000));                 // beq not taken
        put(2, enc_b(8, 3, 1, 3'b001));                 // bne taken
        put(2, enc_sw(12'h088, 1, 0));
        put(2, enc_sw(4, 3, 0));
        put(2, enc_jal(12, 4));                         // at 0x38
        put(2, enc_sw(12'h08c, 1, 0));
        put(2, enc_sw(12'h090, 1, 0));
        put(2, enc_sw(8, 4, 0));
        put(2, enc_i(88, 0, 3'b000, 5, 7'h13));
        put(2, enc_i(0, 5, 3'b000, 6, 7'h67));          // jalr at 0x4c
        put(2, enc_sw(12'h094, 1, 0));
        put(2, enc_sw(12'h098, 1, 0));
        put(2, enc_sw(12, 6, 0));
        put(2, enc_sw(MARKER_ADDR, 0, 0));
        expect_store(2, 0,  32'd5);
        expect_store(2, 4,  32'hFFFF_FFFF);
        expect_store(2, 8,  32'h0000_003C);
        expect_store(2, 12, 32'h0000_0050);
        expect_store(2, MARKER_ADDR, 32'h0);
        // Writes to x0 must vanish
        row_name[3] = "x0_writes";
        put(3, enc_i(123, 0, 3'b000, 0, 7'h13));
        put(3, enc_sw(0, 0, 0));
        put(3, enc_lui(20'hABCDE, 0));
        put(3, enc_r(7'h00, 0, 0, 3'b000, 1));
        put(3, enc_sw(4, 1, 0));
        put(3, enc_i(7, 0, 3'b000, 2, 7'h13));
        put(3, enc_r(7'h00, 2, 2, 3'b000, 0));
        put(3, enc_sw(8, 0, 0));
        put(3, enc_sw(12, 2, 0));
        put(3, enc_sw(MARKER_ADDR, 0, 0));
        expect_store(3, 0,  32'h0);
        expect_store(3, 4,  32'h0);
        expect_store(3, 8,  32'h0);
        expect_store(3, 12, 32'd7);
        expect_store(3, MARKER_ADDR, 32'h0);
    endtask

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("ERROR @%0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    // ==================================================================
    // Main sequence
    // ==================================================================

    initial begin
        int  cycles;
        bit  marker;
        seed              = 32'h188749ca;
        errors            = 0;
        timed_out         = 1'b0;
        rst_n             = 1'b0;
        instruction_grant = 1'b0;
        build_table();
        for (int r = 0; r < NUM_ROWS && !timed_out; r++) begin
            @(posedge clk);
            rst_n <= 1'b0;
            for (int w = 0; w < PROG_WORDS; w++) begin
                imem[w] = (w < prog_len[r]) ? prog[r][w] : 32'h0000_006f;  // jal x0,0
            end
            repeat (5) @(posedge clk);
            rst_n  <= 1'b1;
            cycles = 0;
            marker = 1'b0;
            while (!marker && !timed_out) begin
                @(negedge clk);
                cycles++;
                marker = (st_addr.size() > 0) && (st_addr[st_addr.size()-1] == MARKER_ADDR);
                if (!marker && cycles >= ROW_CYCLES) begin
                    timed_out = 1'b1;
                    $display("Row %s never reached its marker store within %0d cycles",
                             row_name[r], ROW_CYCLES);
                end
            end
            if (marker) begin
                check({row_name[r], " store count"}, st_addr.size(), exp_count[r]);
                check({row_name[r], " load count"}, loads, exp_loads[r]);
                for (int k = 0; k < exp_count[r] && k < st_addr.size(); k++) begin
                    check($sformatf("%s store %0d addr", row_name[r], k),
                          st_addr[k], exp_addr[r][k]);
                    check($sformatf("%s store %0d data", row_name[r], k),
                          st_data[k], exp_data[r][k]);
                end
            end
        end
        $display("Checks done: %0d errors, %0d timeouts, %0d assertion failures",
                 errors, timed_out, i_dut.i_asserts.fail_count);
        if (errors == 0 && !timed_out && i_dut.i_asserts.fail_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* vlog.f */
+incdir+.
core_pkg.sv
pipe_reg.sv
regfile.sv
decode_stage.sv
hazard_unit.sv
execute_stage.sv
core.sv
core_asserts.sv
tb_core.sv
